//--- compile.f
hdl/arm_pkg.sv
hdl/reg_use_decode.sv
hdl/cond_check.sv
hdl/hazard_scoreboard.sv
hdl/issue_ctl.sv
hdl/issue_stage.sv
dv/tb_clkgen.sv
dv/issue_asserts.sv
dv/tb_issue.sv

//--- dv/issue_asserts.sv
`timescale 1ns/1ps

module issue_asserts (
	input logic           clk,
	input logic           Nrst,
	input logic           stall_1a,
	input logic           stall_0a,
	input logic           bubble_2a,
	input arm_pkg::word_t pc_2a,
	input arm_pkg::word_t insn_2a
);

	// the first edge after reset release still shows an empty stage 2a.
	assert property (@(posedge clk) $rose(Nrst) |-> bubble_2a)
		else $error("bubble_2a is low in the first cycle after reset release");

	// back-pressure freezes the stage 2a registers.
	assert property (@(posedge clk) disable iff (!Nrst)
		stall_1a |=> ($stable(bubble_2a) && $stable(pc_2a) && $stable(insn_2a)))
		else $error("stage 2a outputs changed while stall_1a was high");

	assert property (@(posedge clk) disable iff (!Nrst) stall_1a |-> stall_0a)
		else $error("stall_0a is low while stall_1a is high");

endmodule

bind issue_stage issue_asserts u_asserts (
	.clk       (clk),
	.Nrst      (Nrst),
	.stall_1a  (stall_1a),
	.stall_0a  (stall_0a),
	.bubble_2a (bubble_2a),
	.pc_2a     (pc_2a),
	.insn_2a   (insn_2a)
);

//--- dv/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
	parameter int HALF_PERIOD  = 5,
	parameter int RESET_CYCLES = 3
) (
	output logic clk,
	output logic Nrst
);

	initial
	begin
		clk = 1'b0;
		forever
			#(HALF_PERIOD) clk = ~clk;
	end

	// reset is released on a falling edge, away from the sampling edge.
	initial
	begin
		Nrst = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		Nrst = 1'b1;
	end

endmodule

//--- dv/tb_issue.sv
`timescale 1ns/1ps

module tb_issue;

	localparam int SB_DEPTH     = 2;
	localparam int NUM_CYCLES   = 2000;
	localparam int RESET_CYCLES = 3;
	localparam int CLK_PERIOD   = 10;
	localparam int TIMEOUT_NS   = (NUM_CYCLES + RESET_CYCLES + 20) * CLK_PERIOD;

	logic           clk;
	logic           Nrst;
	logic           stall_1a;
	logic           flush;
	logic           bubble_1a;
	arm_pkg::word_t insn_1a;
	arm_pkg::word_t pc_1a;
	arm_pkg::word_t cpsr_1a;
	logic           stall_0a;
	logic           bubble_2a;
	arm_pkg::word_t pc_2a;
	arm_pkg::word_t insn_2a;

	integer         seed;
	int             errors;
	int             checks;

	// reference model state.
	logic           m_use_cpsr;
	logic [15:0]    m_use_regs;
	logic           m_def_cpsr;
	logic [15:0]    m_def_regs;
	logic           m_wait;
	logic           m_stall;
	logic           m_accept;
	logic           m_flush_pend;
	logic           fl_cpsr [SB_DEPTH];
	logic [15:0]    fl_regs [SB_DEPTH];
	logic           exp_bubble;
	logic [31:0]    exp_pc;
	logic [31:0]    exp_insn;

	tb_clkgen #(
		.HALF_PERIOD  (CLK_PERIOD / 2),
		.RESET_CYCLES (RESET_CYCLES)
	) u_clkgen (
		.clk  (clk),
		.Nrst (Nrst)
	);

	issue_stage #(
		.SB_DEPTH (SB_DEPTH)
	) i_dut (
		.clk       (clk),
		.Nrst      (Nrst),
		.stall_1a  (stall_1a),
		.flush     (flush),
		.bubble_1a (bubble_1a),
		.insn_1a   (insn_1a),
		.pc_1a     (pc_1a),
		.cpsr_1a   (cpsr_1a),
		.stall_0a  (stall_0a),
		.bubble_2a (bubble_2a),
		.pc_2a     (pc_2a),
		.insn_2a   (insn_2a)
	);

	////////////////////
	// random helpers.
	function automatic logic [31:0] rand_word();
		logic [31:0] w;
		w = $random(seed);
		return w;
	endfunction

	function automatic logic chance(input logic [31:0] pct);
		logic [31:0] w;
		w = rand_word();
		return (w % 32'd100) < pct;
	endfunction

	// mostly R0 to R3 so that hazards are frequent, sometimes the PC.
	function automatic logic [3:0] pick_reg();
		logic [31:0] w;
		w = rand_word();
		return (w[4:2] == 3'd0) ? 4'd15 : {2'b00, w[1:0]};
	endfunction

	// the PC is never tracked as a hazard.
	function automatic logic [15:0] reg_bit(input logic [3:0] r);
		return (r == 4'd15) ? 16'd0 : (16'd1 << r);
	endfunction

	// even codes test a flag term, the odd code next to it is its inverse.
	function automatic logic cond_passes(input logic [3:0] c, input logic [31:0] f);
		logic base;
		case (c[3:1])
			3'd0: base = f[30];
			3'd1: base = f[29];
			3'd2: base = f[31];
			3'd3: base = f[28];
			3'd4: base = f[29] && !f[30];
			3'd5: base = (f[31] == f[28]);
			3'd6: base = !f[30] && (f[31] == f[28]);
			default: base = 1'b1;
		endcase
		return base ^ c[0];
	endfunction

	task automatic compare_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	////////////////////
	// instruction generator with the expected use and define masks.
	task automatic make_insn(output logic [31:0] insn, output logic u_cpsr,
		output logic [15:0] u_regs, output logic d_cpsr, output logic [15:0] d_regs);
		logic [31:0] sel;
		logic [31:0] r;
		logic [3:0]  cond;
		logic [3:0]  ra;
		logic [3:0]  rb;
		logic [3:0]  rc;
		logic [3:0]  rd;
		logic [3:0]  opc;
		logic        s;
		logic [4:0]  amt;
		logic [15:0] list;
		sel = rand_word();
		r = rand_word();
		cond = sel[31:28];
		ra = pick_reg();
		rb = pick_reg();
		rc = pick_reg();
		rd = pick_reg();
		opc = r[24:21];
		// compare opcodes always set the flags.
		s = r[20] || (opc[3:2] == 2'b10);
		amt = r[8] ? 5'd0 : r[13:9];
		list = {r[15], 11'd0, r[3:0]};
		u_cpsr = (cond != 4'he) && (cond != 4'hf);
		u_regs = 16'd0;
		d_cpsr = 1'b0;
		d_regs = 16'd0;
		case (sel[2:0])
			3'd0, 3'd1:
			begin
				if (sel[0])
					insn = {cond, 3'b001, opc, s, ra, rd, r[11:0]};
				else if (r[4])
					insn = {cond, 3'b000, opc, s, ra, rd, rc, 1'b0, r[6:5], 1'b1, rb};
				else
					insn = {cond, 3'b000, opc, s, ra, rd, amt, r[6:5], 1'b0, rb};
				if (!sel[0])
					u_regs = reg_bit(rb) | (r[4] ? reg_bit(rc) : 16'd0);
				if ((opc != 4'hd) && (opc != 4'hf))
					u_regs = u_regs | reg_bit(ra);
				// a zero immediate shift passes the carry (LSL) or rotates it in (RRX).
				if (!sel[0] && !r[4] && (amt == 5'd0) && (r[6:5] == 2'b00 || r[6:5] == 2'b11))
					u_cpsr = 1'b1;
				d_cpsr = s;
				d_regs = (opc[3:2] == 2'b10) ? 16'd0 : reg_bit(rd);
			end
			3'd2:
			begin
				if (r[25])
					insn = {cond, 3'b011, r[24:20], ra, rd, r[11:5], 1'b0, rb};
				else
					insn = {cond, 3'b010, r[24:20], ra, rd, r[11:0]};
				u_regs = reg_bit(ra) | (r[25] ? reg_bit(rb) : 16'd0) |
					(r[20] ? 16'd0 : reg_bit(rd));
				d_regs = (r[20] ? reg_bit(rd) : 16'd0) |
					((!r[24] || r[21]) ? reg_bit(ra) : 16'd0);
			end
			3'd3:
			begin
				insn = {cond, 3'b100, r[24:20], ra, list};
				u_regs = reg_bit(ra) | (r[20] ? 16'd0 : (list & 16'h7fff));
				d_cpsr = r[22];
				d_regs = (r[21] ? reg_bit(ra) : 16'd0) | (r[20] ? (list & 16'h7fff) : 16'd0);
			end
			3'd4:
			begin
				insn = {cond, 4'b1011, r[23:0]};
				d_regs = reg_bit(4'd14);
			end
			3'd5:
			begin
				insn = {cond, 5'b00010, r[22], 2'b00, 4'hf, rd, 12'h000};
				u_cpsr = u_cpsr || !r[22];
				d_regs = reg_bit(rd);
			end
			3'd6:
			begin
				if (r[27])
					insn = {cond, 5'b00010, r[22], 2'b10, 4'h9, 4'hf, 8'h00, rb};
				else
					insn = {cond, 2'b00, r[25], 2'b10, r[22], 2'b10, 4'h8, 4'hf,
						(r[25] ? r[11:0] : {8'h00, rb})};
				u_regs = (r[27] || !r[25]) ? reg_bit(rb) : 16'd0;
				d_cpsr = 1'b1;
			end
			default:
			begin
				insn = {cond, 6'b000000, r[21], r[20], rd, ra, rc, 4'b1001, rb};
				u_regs = (r[21] ? reg_bit(ra) : 16'd0) | reg_bit(rc) | reg_bit(rb);
				d_cpsr = r[20];
				d_regs = reg_bit(rd);
			end
		endcase
	endtask

	task automatic check_registered();
		compare_value("bubble_2a", 32'(bubble_2a), 32'(exp_bubble));
		compare_value("pc_2a", pc_2a, exp_pc);
		compare_value("insn_2a", insn_2a, exp_insn);
	endtask

	////////////////////
	// stimulus and model.
	initial
	begin
		seed = 71;
		errors = 0;
		checks = 0;
		stall_1a = 1'b0;
		flush = 1'b0;
		bubble_1a = 1'b1;
		insn_1a = '0;
		pc_1a = '0;
		cpsr_1a = '0;
		m_flush_pend = 1'b0;
		exp_bubble = 1'b1;
		exp_pc = 32'd0;
		exp_insn = 32'd0;
		for (int i = 0; i < SB_DEPTH; i++)
		begin
			fl_cpsr[i] = 1'b0;
			fl_regs[i] = 16'd0;
		end
		wait (Nrst === 1'b1);
		for (int cyc = 0; cyc < NUM_CYCLES; cyc++)
		begin
			check_registered();
			bubble_1a = chance(32'd10);
			stall_1a = chance(32'd10);
			flush = chance(32'd10);
			make_insn(insn_1a, m_use_cpsr, m_use_regs, m_def_cpsr, m_def_regs);
			pc_1a = pc_1a + 32'd4;
			cpsr_1a = rand_word();
			m_wait = 1'b0;
			for (int i = 0; i < SB_DEPTH; i++)
				m_wait = m_wait || ((m_use_regs & fl_regs[i]) != 16'd0) ||
					(m_use_cpsr && fl_cpsr[i]);
			m_stall = stall_1a || (m_wait && !bubble_1a && !flush);
			m_accept = !stall_1a && !m_wait && !bubble_1a && !flush && !m_flush_pend &&
				cond_passes(insn_1a[31:28], cpsr_1a);
			#1;
			compare_value("stall_0a", 32'(stall_0a), 32'(m_stall));
			if (flush && m_stall)
				m_flush_pend = 1'b1;
			else if (!m_stall)
				m_flush_pend = 1'b0;
			if (!stall_1a)
			begin
				for (int i = SB_DEPTH - 1; i > 0; i--)
				begin
					fl_cpsr[i] = fl_cpsr[i-1];
					fl_regs[i] = fl_regs[i-1];
				end
				fl_cpsr[0] = m_accept && m_def_cpsr;
				fl_regs[0] = m_accept ? m_def_regs : 16'd0;
				exp_bubble = !m_accept;
				exp_pc = pc_1a;
				exp_insn = insn_1a;
			end
			@(negedge clk);
		end
		check_registered();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

	// watchdog.
	initial
	begin
		#(TIMEOUT_NS);
		$display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

//--- hdl/arm_pkg.sv
package arm_pkg;

	typedef logic [31:0] word_t;
	typedef logic [15:0] reg_mask_t;
	typedef logic [3:0]  reg_idx_t;
	typedef logic [3:0]  cond_t;
	typedef logic [3:0]  alu_opc_t;

	// flag positions in the CPSR.
	localparam int CPSR_N = 31;
	localparam int CPSR_Z = 30;
	localparam int CPSR_C = 29;
	localparam int CPSR_V = 28;

	////////////////////
	// condition field codes.
	localparam cond_t COND_EQ = 4'h0;
	localparam cond_t COND_NE = 4'h1;
	localparam cond_t COND_CS = 4'h2;
	localparam cond_t COND_CC = 4'h3;
	localparam cond_t COND_MI = 4'h4;
	localparam cond_t COND_PL = 4'h5;
	localparam cond_t COND_VS = 4'h6;
	localparam cond_t COND_VC = 4'h7;
	localparam cond_t COND_HI = 4'h8;
	localparam cond_t COND_LS = 4'h9;
	localparam cond_t COND_GE = 4'ha;
	localparam cond_t COND_LT = 4'hb;
	localparam cond_t COND_GT = 4'hc;
	localparam cond_t COND_LE = 4'hd;
	localparam cond_t COND_AL = 4'he;
	localparam cond_t COND_NV = 4'hf;

	////////////////////
	// data-processing opcodes.
	localparam alu_opc_t ALU_AND = 4'h0;
	localparam alu_opc_t ALU_EOR = 4'h1;
	localparam alu_opc_t ALU_SUB = 4'h2;
	localparam alu_opc_t ALU_RSB = 4'h3;
	localparam alu_opc_t ALU_ADD = 4'h4;
	localparam alu_opc_t ALU_ADC = 4'h5;
	localparam alu_opc_t ALU_SBC = 4'h6;
	localparam alu_opc_t ALU_RSC = 4'h7;
	localparam alu_opc_t ALU_TST = 4'h8;
	localparam alu_opc_t ALU_TEQ = 4'h9;
	localparam alu_opc_t ALU_CMP = 4'ha;
	localparam alu_opc_t ALU_CMN = 4'hb;
	localparam alu_opc_t ALU_ORR = 4'hc;
	localparam alu_opc_t ALU_MOV = 4'hd;
	localparam alu_opc_t ALU_BIC = 4'he;
	localparam alu_opc_t ALU_MVN = 4'hf;

	// shift type field, insn[6:5].
	localparam logic [1:0] SHIFT_LSL = 2'b00;
	localparam logic [1:0] SHIFT_LSR = 2'b01;
	localparam logic [1:0] SHIFT_ASR = 2'b10;
	localparam logic [1:0] SHIFT_ROR = 2'b11;

	////////////////////
	// class match patterns, used with casez in priority order.
	localparam word_t DECODE_ALU_MULT      = 32'b????_0000_00??_????_????_????_1001_????;
	localparam word_t DECODE_ALU_MRS       = 32'b????_0001_0?00_1111_????_0000_0000_0000;
	localparam word_t DECODE_ALU_MSR       = 32'b????_0001_0?10_1001_1111_0000_0000_????;
	localparam word_t DECODE_ALU_MSR_FLAGS = 32'b????_00?1_0?10_1000_1111_????_????_????;
	localparam word_t DECODE_ALU_SWP       = 32'b????_0001_0?00_????_????_0000_1001_????;
	localparam word_t DECODE_ALU_BX        = 32'b????_0001_0010_1111_1111_1111_0001_????;
	localparam word_t DECODE_ALU_HDATA_REG = 32'b????_000?_?0??_????_????_0000_1??1_????;
	localparam word_t DECODE_ALU_HDATA_IMM = 32'b????_000?_?1??_????_????_????_1??1_????;
	localparam word_t DECODE_ALU           = 32'b????_00??_????_????_????_????_????_????;
	localparam word_t DECODE_LDRSTR_UNDEF  = 32'b????_011?_????_????_????_????_???1_????;
	localparam word_t DECODE_LDRSTR        = 32'b????_01??_????_????_????_????_????_????;
	localparam word_t DECODE_LDMSTM        = 32'b????_100?_????_????_????_????_????_????;
	localparam word_t DECODE_BRANCH        = 32'b????_101?_????_????_????_????_????_????;
	localparam word_t DECODE_LDCSTC        = 32'b????_110?_????_????_????_????_????_????;
	localparam word_t DECODE_CDP           = 32'b????_1110_????_????_????_????_???0_????;
	localparam word_t DECODE_MRCMCR        = 32'b????_1110_????_????_????_????_???1_????;
	localparam word_t DECODE_SWI           = 32'b????_1111_????_????_????_????_????_????;

endpackage

//--- hdl/cond_check.sv
`timescale 1ns/1ps

module cond_check (
	input  arm_pkg::cond_t cond,
	input  arm_pkg::word_t cpsr,
	output logic           cond_met
);

	logic n;
	logic z;
	logic c;
	logic v;

	assign n = cpsr[arm_pkg::CPSR_N];
	assign z = cpsr[arm_pkg::CPSR_Z];
	assign c = cpsr[arm_pkg::CPSR_C];
	assign v = cpsr[arm_pkg::CPSR_V];

	always_comb
	begin
		case (cond)
			arm_pkg::COND_EQ: cond_met = z;
			arm_pkg::COND_NE: cond_met = !z;
			arm_pkg::COND_CS: cond_met = c;
			arm_pkg::COND_CC: cond_met = !c;
			arm_pkg::COND_MI: cond_met = n;
			arm_pkg::COND_PL: cond_met = !n;
			arm_pkg::COND_VS: cond_met = v;
			arm_pkg::COND_VC: cond_met = !v;
			arm_pkg::COND_HI: cond_met = c && !z;
			arm_pkg::COND_LS: cond_met = !c || z;
			arm_pkg::COND_GE: cond_met = (n == v);
			arm_pkg::COND_LT: cond_met = (n != v);
			arm_pkg::COND_GT: cond_met = !z && (n == v);
			arm_pkg::COND_LE: cond_met = z || (n != v);
			arm_pkg::COND_AL: cond_met = 1'b1;
			// NV is the never condition on this core.
			default: cond_met = 1'b0;
		endcase
	end

endmodule

//--- hdl/hazard_scoreboard.sv
`timescale 1ns/1ps

module hazard_scoreboard #(
	parameter int SB_DEPTH = 2
) (
	input  logic               clk,
	input  logic               Nrst,
	input  logic               advance,
	input  logic               accept,
	input  logic               use_cpsr,
	input  arm_pkg::reg_mask_t use_regs,
	input  logic               def_cpsr,
	input  arm_pkg::reg_mask_t def_regs,
	output logic               waiting
);

	// entry 0 is the instruction in 2a, the last one is SB_DEPTH stages out.
	logic               cpsr_q [SB_DEPTH];
	arm_pkg::reg_mask_t regs_q [SB_DEPTH];
	logic               cpsr_any;
	arm_pkg::reg_mask_t regs_any;

	always_ff @(posedge clk or negedge Nrst)
	begin
		if (!Nrst)
		begin
			for (int i = 0; i < SB_DEPTH; i++)
			begin
				cpsr_q[i] <= 1'b0;
				regs_q[i] <= '0;
			end
		end
		else if (advance)
		begin
			// a bubble enters as an empty entry.
			cpsr_q[0] <= accept & def_cpsr;
			regs_q[0] <= accept ? def_regs : '0;
			for (int i = 1; i < SB_DEPTH; i++)
			begin
				cpsr_q[i] <= cpsr_q[i-1];
				regs_q[i] <= regs_q[i-1];
			end
		end
	end

	always_comb
	begin
		cpsr_any = 1'b0;
		regs_any = '0;
		for (int i = 0; i < SB_DEPTH; i++)
		begin
			cpsr_any = cpsr_any | cpsr_q[i];
			regs_any = regs_any | regs_q[i];
		end
	end

	assign waiting = (use_cpsr & cpsr_any) | (|(use_regs & regs_any));

endmodule

//--- hdl/issue_ctl.sv
`timescale 1ns/1ps

module issue_ctl (
	input  logic           clk,
	input  logic           Nrst,
	input  logic           stall_1a,
	input  logic           flush,
	input  logic           bubble_1a,
	input  logic           waiting,
	input  logic           cond_met,
	input  arm_pkg::word_t insn_1a,
	input  arm_pkg::word_t pc_1a,
	output logic           stall_0a,
	output logic           advance,
	output logic           accept,
	output logic           bubble_2a,
	output arm_pkg::word_t pc_2a,
	output arm_pkg::word_t insn_2a
);

	typedef enum logic {
		FLUSH_IDLE,
		FLUSH_PENDING
	} flush_state_t;

	flush_state_t flush_state;

	assign advance = !stall_1a;
	// a waiting instruction only holds the front end if it is real and not killed.
	assign stall_0a = stall_1a || (waiting && !bubble_1a && !flush);
	assign accept = advance && !waiting && !bubble_1a && cond_met && !flush &&
		(flush_state == FLUSH_IDLE);

	////////////////////
	// flush memory.
	// a flush that cannot be taken now kills the next instruction to leave.
	always_ff @(posedge clk or negedge Nrst)
	begin
		if (!Nrst)
			flush_state <= FLUSH_IDLE;
		else if (flush && stall_0a)
			flush_state <= FLUSH_PENDING;
		else if (!stall_0a)
			flush_state <= FLUSH_IDLE;
	end

	////////////////////
	// stage 2a registers.
	always_ff @(posedge clk or negedge Nrst)
	begin
		if (!Nrst)
		begin
			bubble_2a <= 1'b1;
			pc_2a <= '0;
			insn_2a <= '0;
		end
		else if (advance)
		begin
			// anything not accepted goes down the pipe as a bubble.
			bubble_2a <= !accept;
			pc_2a <= pc_1a;
			insn_2a <= insn_1a;
		end
	end

endmodule

//--- hdl/issue_stage.sv
`timescale 1ns/1ps

module issue_stage #(
	parameter int SB_DEPTH = 2
) (
	input  logic           clk,
	input  logic           Nrst,
	input  logic           stall_1a,
	input  logic           flush,
	input  logic           bubble_1a,
	input  arm_pkg::word_t insn_1a,
	input  arm_pkg::word_t pc_1a,
	input  arm_pkg::word_t cpsr_1a,
	output logic           stall_0a,
	output logic           bubble_2a,
	output arm_pkg::word_t pc_2a,
	output arm_pkg::word_t insn_2a
);

	logic               use_cpsr;
	arm_pkg::reg_mask_t use_regs;
	logic               def_cpsr;
	arm_pkg::reg_mask_t def_regs;
	logic               cond_met;
	logic               waiting;
	logic               advance;
	logic               accept;

	reg_use_decode u_decode (
		.insn     (insn_1a),
		.use_cpsr (use_cpsr),
		.use_regs (use_regs),
		.def_cpsr (def_cpsr),
		.def_regs (def_regs)
	);

	cond_check u_cond (
		.cond     (insn_1a[31:28]),
		.cpsr     (cpsr_1a),
		.cond_met (cond_met)
	);

	hazard_scoreboard #(
		.SB_DEPTH (SB_DEPTH)
	) u_scoreboard (
		.clk      (clk),
		.Nrst     (Nrst),
		.advance  (advance),
		.accept   (accept),
		.use_cpsr (use_cpsr),
		.use_regs (use_regs),
		.def_cpsr (def_cpsr),
		.def_regs (def_regs),
		.waiting  (waiting)
	);

	issue_ctl u_ctl (
		.clk       (clk),
		.Nrst      (Nrst),
		.stall_1a  (stall_1a),
		.flush     (flush),
		.bubble_1a (bubble_1a),
		.waiting   (waiting),
		.cond_met  (cond_met),
		.insn_1a   (insn_1a),
		.pc_1a     (pc_1a),
		.stall_0a  (stall_0a),
		.advance   (advance),
		.accept    (accept),
		.bubble_2a (bubble_2a),
		.pc_2a     (pc_2a),
		.insn_2a   (insn_2a)
	);

endmodule

//--- hdl/reg_use_decode.sv
`timescale 1ns/1ps

module reg_use_decode (
	input  arm_pkg::word_t     insn,
	output logic               use_cpsr,
	output arm_pkg::reg_mask_t use_regs,
	output logic               def_cpsr,
	output arm_pkg::reg_mask_t def_regs
);

	arm_pkg::reg_idx_t  rn;
	arm_pkg::reg_idx_t  rd;
	arm_pkg::reg_idx_t  rs;
	arm_pkg::reg_idx_t  rm;
	arm_pkg::reg_idx_t  rd_mul;
	arm_pkg::reg_idx_t  rn_mul;
	arm_pkg::alu_opc_t  alu_opc;
	arm_pkg::reg_mask_t reg_list;
	logic               cond_matters;
	logic               single_wb;

	// one-hot register bit that never includes the PC.
	function automatic arm_pkg::reg_mask_t idx_bit(input arm_pkg::reg_idx_t r);
		if (r == 4'd15)
			return '0;
		return arm_pkg::reg_mask_t'(1) << r;
	endfunction

	function automatic logic alu_writes_rd(input arm_pkg::alu_opc_t op);
		case (op)
			arm_pkg::ALU_TST, arm_pkg::ALU_TEQ, arm_pkg::ALU_CMP, arm_pkg::ALU_CMN:
				return 1'b0;
			arm_pkg::ALU_AND, arm_pkg::ALU_EOR, arm_pkg::ALU_SUB, arm_pkg::ALU_RSB,
			arm_pkg::ALU_ADD, arm_pkg::ALU_ADC, arm_pkg::ALU_SBC, arm_pkg::ALU_RSC,
			arm_pkg::ALU_ORR, arm_pkg::ALU_MOV, arm_pkg::ALU_BIC, arm_pkg::ALU_MVN:
				return 1'b1;
			default:
				return 1'b1;
		endcase
	endfunction

	// an immediate shift of zero turns LSL into a carry pass and ROR into RRX.
	function automatic logic shift_needs_carry(input arm_pkg::word_t i);
		if (i[25] || i[4] || (i[11:7] != 5'd0))
			return 1'b0;
		return (i[6:5] == arm_pkg::SHIFT_LSL) || (i[6:5] == arm_pkg::SHIFT_ROR);
	endfunction

	assign rn = insn[19:16];
	assign rd = insn[15:12];
	assign rs = insn[11:8];
	assign rm = insn[3:0];
	// multiply moves the destination up into the Rn field.
	assign rd_mul = insn[19:16];
	assign rn_mul = insn[15:12];
	assign alu_opc = insn[24:21];
	assign reg_list = insn[15:0] & 16'h7fff;
	assign cond_matters = (insn[31:28] != arm_pkg::COND_AL) && (insn[31:28] != arm_pkg::COND_NV);
	// single transfers write back when post-indexed or when W is set.
	assign single_wb = !insn[24] || insn[21];

	always_comb
	begin
		use_cpsr = cond_matters;
		use_regs = '0;
		def_cpsr = 1'b0;
		def_regs = '0;
		casez (insn)
			arm_pkg::DECODE_ALU_MULT:
			begin
				use_regs = (insn[21] ? idx_bit(rn_mul) : '0) | idx_bit(rs) | idx_bit(rm);
				def_cpsr = insn[20];
				def_regs = idx_bit(rd_mul);
			end
			arm_pkg::DECODE_ALU_MRS:
			begin
				use_cpsr = cond_matters || !insn[22];
				def_regs = idx_bit(rd);
			end
			arm_pkg::DECODE_ALU_MSR:
			begin
				use_regs = idx_bit(rm);
				def_cpsr = 1'b1;
			end
			arm_pkg::DECODE_ALU_MSR_FLAGS:
			begin
				use_regs = insn[25] ? '0 : idx_bit(rm);
				def_cpsr = 1'b1;
			end
			arm_pkg::DECODE_ALU_SWP:
			begin
				use_regs = idx_bit(rn) | idx_bit(rm);
				def_regs = idx_bit(rd);
			end
			arm_pkg::DECODE_ALU_BX:
				use_regs = idx_bit(rm);
			arm_pkg::DECODE_ALU_HDATA_REG, arm_pkg::DECODE_ALU_HDATA_IMM:
			begin
				use_regs = idx_bit(rn) | (insn[20] ? '0 : idx_bit(rd)) |
					(insn[22] ? '0 : idx_bit(rm));
				def_regs = (insn[20] ? idx_bit(rd) : '0) | (single_wb ? idx_bit(rn) : '0);
			end
			arm_pkg::DECODE_ALU:
			begin
				use_cpsr = cond_matters || shift_needs_carry(insn);
				use_regs = (insn[25] ? '0 : (insn[4] ? (idx_bit(rs) | idx_bit(rm)) : idx_bit(rm))) |
					(((alu_opc != arm_pkg::ALU_MOV) && (alu_opc != arm_pkg::ALU_MVN)) ?
						idx_bit(rn) : '0);
				def_cpsr = insn[20];
				def_regs = alu_writes_rd(alu_opc) ? idx_bit(rd) : '0;
			end
			arm_pkg::DECODE_LDRSTR_UNDEF:
				use_cpsr = cond_matters;
			arm_pkg::DECODE_LDRSTR:
			begin
				use_regs = idx_bit(rn) | (insn[25] ? idx_bit(rm) : '0) |
					(insn[20] ? '0 : idx_bit(rd));
				def_regs = (insn[20] ? idx_bit(rd) : '0) | (single_wb ? idx_bit(rn) : '0);
			end
			arm_pkg::DECODE_LDMSTM:
			begin
				use_regs = idx_bit(rn) | (insn[20] ? '0 : reg_list);
				// the S bit may restore the CPSR, so treat it as a define.
				def_cpsr = insn[22];
				def_regs = (insn[21] ? idx_bit(rn) : '0) | (insn[20] ? reg_list : '0);
			end
			arm_pkg::DECODE_BRANCH:
				def_regs = insn[24] ? idx_bit(4'd14) : '0;
			arm_pkg::DECODE_LDCSTC:
			begin
				use_regs = idx_bit(rn);
				def_regs = insn[21] ? idx_bit(rn) : '0;
			end
			arm_pkg::DECODE_MRCMCR:
			begin
				use_regs = insn[20] ? '0 : idx_bit(rd);
				def_regs = insn[20] ? idx_bit(rd) : '0;
			end
			arm_pkg::DECODE_CDP, arm_pkg::DECODE_SWI:
				use_cpsr = cond_matters;
			default:
				use_cpsr = cond_matters;
		endcase
	end

endmodule

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_issue -f compile.f -o tb_issue \
	&& ./obj_dir/tb_issue | tee /dev/stderr | grep -q "^Simulation PASSED$" \
	&& echo "run_sim: testbench passed" \
	|| { echo "run_sim: build or testbench failed"; exit 1; }
